// ==== source/aluPkg.sv ====
/*
 * Datapath types shared by the ALU core, shifter and BCD unit
 * Operator codes, word and byte types, CCR layout and size constants
 * Modules pull it in with a wildcard import in their header
 */
`default_nettype none

package aluPkg;

	localparam int wordWidth = 16;
	localparam int byteWidth = 8;
	localparam int ccrWidth = 5;	// X N Z V C
	localparam int halfCarryBit = 4;	// Carry out of the low nibble

	typedef logic [wordWidth-1:0] dataWord;
	typedef logic [byteWidth-1:0] dataByte;

	// Code 0 and 19..31 are undefined
	typedef enum logic [4:0] {
		opAnd = 5'd1,
		opOr,
		opEor,
		opExt,
		opAdd,
		opAddx,
		opSub,
		opSubx,
		opAsl,
		opAsr,
		opLsl,
		opLsr,
		opRol,
		opRor,
		opRoxl,
		opRoxr,
		opAbcd,
		opSbcd
	} aluOp;

	// Same bit order as the 68000 CCR
	typedef struct packed {
		logic x;
		logic n;
		logic z;
		logic v;
		logic c;
	} ccrFlags;

	// Command register layout, op in the upper five bits
	typedef struct packed {
		aluOp op;
		logic isByte;
	} aluCommand;

	// Shifter side flags
	typedef struct packed {
		logic carryOut;
		logic xOut;
		logic overflow;	// ASL only
	} shiftFlags;

endpackage

`default_nettype wire

// ==== source/busPkg.sv ====
/*
 * Wishbone classic request and response bundles plus the register map
 * Used by the register block, the top level and the testbench
 */
`default_nettype none

package busPkg;

	localparam int busWidth = 16;

	typedef logic [2:0] regAddr;	// Word address
	typedef logic [busWidth-1:0] busWord;

	// Master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		regAddr adr;
		busWord dat;
	} wbRequest;

	// Slave to master
	typedef struct packed {
		logic ack;
		busWord dat;
	} wbResponse;

	// Register map
	localparam regAddr addrOperandA = 3'd0;	// Source operand, R/W
	localparam regAddr addrOperandD = 3'd1;	// Destination operand, R/W
	localparam regAddr addrCommand = 3'd2;	// Write executes
	localparam regAddr addrResult = 3'd3;	// Read only
	localparam regAddr addrCcr = 3'd4;	// Low five bits

endpackage

`default_nettype wire

// ==== source/aluShifter.sv ====
/*
 * One-place shift and rotate of byte or word operand
 * Decodes its own direction and fill bit from the operator
 * Byte results come back sign-extended
 */
`timescale 1ns/1ps
`default_nettype none

module aluShifter import aluPkg::*; (
	input wire dataWord operand,
	input wire aluOp op,
	input wire isByte,
	input wire xIn,
	output dataWord shifted,
	output shiftFlags flags
);

	logic shiftRight;
	logic msb, nextBit;	// Sized top two bits
	logic fill, outBit;
	dataByte byteShift;
	dataWord wordShift;

	always_comb begin
		msb = isByte ? operand[byteWidth-1] : operand[wordWidth-1];
		nextBit = isByte ? operand[byteWidth-2] : operand[wordWidth-2];
		shiftRight = op inside {opAsr, opLsr, opRor, opRoxr};

		// Bit entering the vacated end
		case (op)
			opAsr, opRol: fill = msb;	// Sign copy or rotated msb
			opRor: fill = operand[0];
			opRoxl, opRoxr: fill = xIn;	// Through X
			default: fill = 1'b0;	// LSL, LSR, ASL
		endcase

		outBit = shiftRight ? operand[0] : msb;

		if (shiftRight) begin
			byteShift = {fill, operand[byteWidth-1:1]};
			wordShift = {fill, operand[wordWidth-1:1]};
		end else begin
			byteShift = {operand[byteWidth-2:0], fill};
			wordShift = {operand[wordWidth-2:0], fill};
		end

		shifted = isByte ? {{byteWidth{byteShift[byteWidth-1]}}, byteShift} : wordShift;

		flags.carryOut = outBit;
		flags.xOut = (op inside {opRol, opRor}) ? xIn : outBit;	// ROL/ROR keep X
		// Sign change on arithmetic left
		flags.overflow = (op == opAsl) & (msb ^ nextBit);
	end

endmodule

`default_nettype wire

// ==== source/bcdCorrect.sv ====
/*
 * Decimal adjust of a binary byte sum or difference
 * Fed from the core adder; gives the BCD byte, decimal carry and V
 */
`timescale 1ns/1ps
`default_nettype none

module bcdCorrect import aluPkg::*; (
	input wire dataByte binResult,
	input wire halfCarry,
	input wire isAdd,
	input wire xIn,	// X as the binary step leaves it
	output dataByte bcdResult,
	output logic decimalCarry,
	output logic overflow
);

	logic lowFix, highFix;
	logic [byteWidth:0] lowAdj;	// Extra bit catches the carry
	logic [byteWidth-halfCarryBit:0] highNib;

	// Nibble holds 10..15
	function automatic logic above9(input logic [3:0] nib);
		return nib[3] & (nib[2] | nib[1]);
	endfunction

	always_comb begin
		lowFix = halfCarry | (isAdd & above9(binResult[halfCarryBit-1:0]));

		if (isAdd) begin
			lowAdj = {1'b0, binResult} + (lowFix ? 9'd6 : 9'd0);
			// High digit needs fixing on carry or digit past 9
			highFix = xIn | lowAdj[byteWidth] | above9(lowAdj[byteWidth-1:halfCarryBit]);
			highNib = lowAdj[byteWidth:halfCarryBit] + (highFix ? 5'd6 : 5'd0);
			overflow = highNib[3] & ~binResult[byteWidth-1];
		end else begin
			lowAdj = {1'b0, binResult} - (lowFix ? 9'd6 : 9'd0);
			highFix = xIn;	// Borrow out of binary step
			highNib = lowAdj[byteWidth:halfCarryBit] - (highFix ? 5'd6 : 5'd0);
			overflow = ~highNib[3] & binResult[byteWidth-1];
		end

		bcdResult = {highNib[3:0], lowAdj[halfCarryBit-1:0]};
		decimalCarry = highNib[4] | xIn;
	end

endmodule

`default_nettype wire

// ==== source/aluCore.sv ====
/*
 * Combinational ALU: adder/subtractor, logic ops, shifter and BCD path
 * Selects the result by operator and builds the next CCR
 * opValid low means the code is undefined and nothing should load
 */
`timescale 1ns/1ps
`default_nettype none

module aluCore import aluPkg::*; (
	input wire dataWord operandA,
	input wire dataWord operandD,
	input wire aluCommand command,
	input wire ccrFlags ccr,
	output dataWord result,
	output ccrFlags newCcr,
	output logic opValid
);

	logic isAdd, useX, isBcd, sizeByte;
	logic carryIn;
	logic [wordWidth:0] wordSum;
	logic [byteWidth:0] byteSum;	// Only for the byte carry
	logic carry, overflow, halfCarry;
	logic msbA, msbD, msbR;
	dataWord rawResult;
	logic zeroNow, negNow;

	dataWord shifted;
	shiftFlags sFlags;
	dataByte bcdResult;
	logic bcdCarry, bcdOverflow;

	assign isAdd = command.op inside {opAdd, opAddx, opAbcd};
	assign useX = command.op inside {opAddx, opSubx, opAbcd, opSbcd};
	assign isBcd = command.op inside {opAbcd, opSbcd};
	assign sizeByte = command.isByte | isBcd;	// BCD is always byte
	assign carryIn = useX & ccr.x;

	// Data minus address on subtract
	always_comb begin
		if (isAdd) begin
			wordSum = {1'b0, operandD} + {1'b0, operandA} + 17'(carryIn);
			byteSum = {1'b0, operandD[byteWidth-1:0]} + {1'b0, operandA[byteWidth-1:0]}
				+ 9'(carryIn);
		end else begin
			wordSum = {1'b0, operandD} - {1'b0, operandA} - 17'(carryIn);
			byteSum = {1'b0, operandD[byteWidth-1:0]} - {1'b0, operandA[byteWidth-1:0]}
				- 9'(carryIn);
		end

		carry = sizeByte ? byteSum[byteWidth] : wordSum[wordWidth];
		msbA = sizeByte ? operandA[byteWidth-1] : operandA[wordWidth-1];
		msbD = sizeByte ? operandD[byteWidth-1] : operandD[wordWidth-1];
		msbR = sizeByte ? byteSum[byteWidth-1] : wordSum[wordWidth-1];

		// Signed overflow, source sign flipped for subtract
		overflow = ((msbA ^ ~isAdd) == msbD) & (msbR != msbD);
		halfCarry = operandA[halfCarryBit] ^ operandD[halfCarryBit] ^ wordSum[halfCarryBit];
	end

	aluShifter shifter (
		.operand(operandA),
		.op(command.op),
		.isByte(command.isByte),
		.xIn(ccr.x),
		.shifted(shifted),
		.flags(sFlags)
	);

	// X input is the byte carry the binary step produces
	bcdCorrect decimal (
		.binResult(wordSum[byteWidth-1:0]),
		.halfCarry(halfCarry),
		.isAdd(isAdd),
		.xIn(byteSum[byteWidth]),
		.bcdResult(bcdResult),
		.decimalCarry(bcdCarry),
		.overflow(bcdOverflow)
	);

	always_comb begin
		case (command.op)
			opAnd: rawResult = operandA & operandD;
			opOr: rawResult = operandA | operandD;
			opEor: rawResult = operandA ^ operandD;
			opExt: rawResult = {{byteWidth{operandA[byteWidth-1]}}, operandA[byteWidth-1:0]};
			opAdd, opAddx, opSub, opSubx: rawResult = wordSum[wordWidth-1:0];
			opAsl, opAsr, opLsl, opLsr,
			opRol, opRor, opRoxl, opRoxr: rawResult = shifted;
			opAbcd, opSbcd: rawResult = {{byteWidth{1'b0}}, bcdResult};	// Upper byte zero
			default: rawResult = '0;
		endcase

		// Byte results sign-extended, BCD excepted
		if (command.isByte && !isBcd)
			result = {{byteWidth{rawResult[byteWidth-1]}}, rawResult[byteWidth-1:0]};
		else
			result = rawResult;
	end

	assign zeroNow = sizeByte ? (result[byteWidth-1:0] == '0) : (result == '0);
	assign negNow = sizeByte ? result[byteWidth-1] : result[wordWidth-1];

	// Flag rules per operator
	always_comb begin
		newCcr = ccr;	// Undefined codes change nothing
		opValid = 1'b1;
		case (command.op)
			opAnd, opOr, opEor, opExt: begin
				newCcr.n = negNow;
				newCcr.z = zeroNow;
				newCcr.v = 1'b0;
				newCcr.c = 1'b0;	// X kept
			end
			opAdd, opSub, opAddx, opSubx: begin
				newCcr.n = negNow;
				// Extended forms only ever clear Z
				newCcr.z = (command.op inside {opAddx, opSubx}) ? (ccr.z & zeroNow) : zeroNow;
				newCcr.v = overflow;
				newCcr.c = carry;
				newCcr.x = carry;
			end
			opAsl, opAsr, opLsl, opLsr,
			opRol, opRor, opRoxl, opRoxr: begin
				newCcr.n = negNow;
				newCcr.z = zeroNow;
				newCcr.v = sFlags.overflow;
				newCcr.c = sFlags.carryOut;
				newCcr.x = sFlags.xOut;
			end
			opAbcd, opSbcd: begin
				newCcr.n = negNow;
				newCcr.z = ccr.z & zeroNow;	// Multi-byte chains
				newCcr.v = bcdOverflow;
				newCcr.c = bcdCarry;
				newCcr.x = bcdCarry;
			end
			default: opValid = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/aluRegs.sv ====
/*
 * Wishbone classic slave with operand, command, result and CCR registers
 * A command write executes in the same cycle and loads result and CCR
 * on the edge that raises ack
 */
`timescale 1ns/1ps
`default_nettype none

module aluRegs import aluPkg::*, busPkg::*; (
	input wire clk,
	input wire reset,
	input wire wbRequest bus,
	output wbResponse busRsp,
	output dataWord operandA,
	output dataWord operandD,
	output aluCommand command,
	output ccrFlags ccr,
	input wire dataWord result,
	input wire ccrFlags newCcr,
	input wire opValid
);

	logic ackReg;
	logic request;	// New transfer this cycle
	logic writeEn;
	logic cmdWrite;

	dataWord aReg, dReg, resReg;
	aluCommand cmdReg;
	ccrFlags ccrReg;

	// Ack low marks first cycle of a request
	assign request = bus.cyc & bus.stb & ~ackReg;
	assign writeEn = request & bus.we;
	assign cmdWrite = writeEn & (bus.adr == addrCommand);

	// Core sees the incoming command while it is being written
	assign command = cmdWrite ? aluCommand'(bus.dat[$bits(aluCommand)-1:0]) : cmdReg;
	assign operandA = aReg;
	assign operandD = dReg;
	assign ccr = ccrReg;

	always_ff @(posedge clk) begin
		if (reset) begin
			ackReg <= 1'b0;
			aReg <= '0;
			dReg <= '0;
			resReg <= '0;
			cmdReg <= '0;	// Undefined op, nothing runs
			ccrReg <= '0;
		end else begin
			ackReg <= request;	// Single cycle pulse

			if (writeEn) begin
				case (bus.adr)
					addrOperandA: aReg <= bus.dat;
					addrOperandD: dReg <= bus.dat;
					addrCommand: cmdReg <= command;	// Kept even if undefined
					addrCcr: ccrReg <= ccrFlags'(bus.dat[ccrWidth-1:0]);
					default: ;	// Result is read only
				endcase
			end

			// Execute on command write
			if (cmdWrite && opValid) begin
				resReg <= result;
				ccrReg <= newCcr;
			end
		end
	end

	// Read mux, address held by master until ack
	always_comb begin
		busRsp.ack = ackReg;
		case (bus.adr)
			addrOperandA: busRsp.dat = aReg;
			addrOperandD: busRsp.dat = dReg;
			addrCommand: busRsp.dat = busWord'(cmdReg);
			addrResult: busRsp.dat = resReg;
			addrCcr: busRsp.dat = busWord'(ccrReg);	// Upper bits zero
			default: busRsp.dat = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/aluTop.sv ====
/*
 * ALU peripheral top level
 * Wishbone register block driving the combinational ALU core
 */
`timescale 1ns/1ps
`default_nettype none

module aluTop import aluPkg::*, busPkg::*; (
	input wire clk,
	input wire reset,
	input wire wbRequest bus,
	output wbResponse busRsp
);

	dataWord operandA, operandD;
	dataWord result;
	aluCommand command;
	ccrFlags ccr, newCcr;
	logic opValid;

	aluRegs regs (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.busRsp(busRsp),
		.operandA(operandA),
		.operandD(operandD),
		.command(command),
		.ccr(ccr),
		.result(result),
		.newCcr(newCcr),
		.opValid(opValid)
	);

	// Pure combinational datapath
	aluCore core (
		.operandA(operandA),
		.operandD(operandD),
		.command(command),
		.ccr(ccr),
		.result(result),
		.newCcr(newCcr),
		.opValid(opValid)
	);

endmodule

`default_nettype wire

// ==== testbench/aluChecker.sv ====
/*
 * Bus monitor with a reference model of the ALU peripheral
 * Shadows the registers from acked writes, checks ack timing and every acked read
 * Prints one line per test when the testbench flags the end of a test
 */
`timescale 1ns/1ps
`default_nettype none

module aluChecker import aluPkg::*, busPkg::*; (
	input wire clk,
	input wire reset,
	input wire wbRequest bus,
	input wire wbResponse busRsp,
	input wire [7:0] testNum,
	input wire testEnd,	// One cycle pulse per finished test
	output int checkCount,
	output int errorCount
);

	dataWord shadowA, shadowD, shadowRes;
	logic [5:0] shadowCmd;	// {op, isByte}
	logic [4:0] shadowCcr;	// X N Z V C
	logic ackExpected;	// New request seen one cycle back
	int testChecks, testErrors;

	function automatic int bcdValue(input int unsigned b);
		return (b >> 4) * 10 + (b & 15);
	endfunction

	function automatic string testName(input int n);
		case (n)
			1: return "register access";
			2: return "logic and EXT";
			3: return "add and subtract";
			4: return "shift and rotate";
			5: return "decimal arithmetic";
			6: return "undefined opcodes";
			default: return "unknown";
		endcase
	endfunction

	// Reference model of one command
	task automatic execute(input logic [5:0] cmd);
		logic [4:0] op;
		logic byteSize, bcd, outBit, fill;
		logic x, n, z, v, c;
		int unsigned a, d, m, top, r, bin, cin;
		int dec;
		op = cmd[5:1];
		bcd = op inside {opAbcd, opSbcd};
		byteSize = cmd[0] | bcd;	// BCD always byte
		m = byteSize ? 'hFF : 'hFFFF;
		top = byteSize ? 'h80 : 'h8000;
		a = shadowA & m;
		d = shadowD & m;
		{x, n, z, v, c} = shadowCcr;
		cin = (op inside {opAddx, opSubx, opAbcd, opSbcd}) ? x : 0;
		v = 1'b0;
		c = 1'b0;
		case (op)
			opAnd: r = a & d;
			opOr: r = a | d;
			opEor: r = a ^ d;
			opExt: r = (shadowA[7] ? 'hFF00 : 0) | (shadowA & 'hFF);
			opAdd, opAddx: begin
				r = d + a + cin;
				c = r > m;
				v = ((a & top) == (d & top)) && ((r & top) != (d & top));	// Like signs in
			end
			opSub, opSubx: begin
				r = d - a - cin;	// Data minus address
				c = d < a + cin;
				v = ((a & top) != (d & top)) && ((r & top) != (d & top));
			end
			opAsl, opLsl, opRol, opRoxl: begin
				outBit = (a & top) != 0;
				fill = (op == opRol) ? outBit : ((op == opRoxl) ? x : 1'b0);
				r = (a << 1) | fill;
				c = outBit;
				v = (op == opAsl) && (((r & top) != 0) != outBit);	// Sign changed
			end
			opAsr, opLsr, opRor, opRoxr: begin
				outBit = a[0];
				fill = (op == opAsr) ? ((a & top) != 0)
					: ((op == opRor) ? outBit : ((op == opRoxr) ? x : 1'b0));
				r = (a >> 1) | (fill ? top : 0);
				c = outBit;
			end
			opAbcd, opSbcd: begin
				dec = (op == opAbcd) ? bcdValue(d) + bcdValue(a) + cin
					: bcdValue(d) - bcdValue(a) - cin;
				bin = (op == opAbcd) ? d + a + cin : d - a - cin;	// Plain binary byte
				c = dec < 0 || dec > 99;
				dec = (dec + 100) % 100;
				r = (dec / 10) * 16 + dec % 10;
				v = (op == opAbcd) ? (r[7] & ~bin[7]) : (~r[7] & bin[7]);
			end
			default: return;	// Nothing loads
		endcase
		r = r & m;
		if (!(op inside {opAnd, opOr, opEor, opExt, opRol, opRor}))
			x = c;
		n = (r & top) != 0;
		z = (op inside {opAddx, opSubx, opAbcd, opSbcd}) ? (z && r == 0) : (r == 0);
		if (byteSize && !bcd && r[7])
			r = r | 'hFF00;	// Byte sign extension
		shadowRes = r[15:0];
		shadowCcr = {x, n, z, v, c};
	endtask

	task automatic compareRead(input regAddr adr, input busWord got);
		busWord expected;
		string name;
		case (adr)
			addrOperandA: expected = shadowA;
			addrOperandD: expected = shadowD;
			addrCommand: expected = busWord'(shadowCmd);
			addrResult: expected = shadowRes;
			addrCcr: expected = busWord'(shadowCcr);
			default: expected = 16'h0000;
		endcase
		case (adr)
			addrOperandA: name = "operandA";
			addrOperandD: name = "operandD";
			addrCommand: name = "command";
			addrResult: name = "result";
			addrCcr: name = "ccr";
			default: name = "unmapped";
		endcase
		checkCount++;
		testChecks++;
		if (got !== expected) begin
			$display("error at %0t ns: busRsp.dat (%s) expected %04h, got %04h",
				$time, name, expected, got);
			errorCount++;
			testErrors++;
		end
	endtask

	// Sampled at the rising edge while ack is up, request still held
	always @(posedge clk) begin
		if (reset) begin
			shadowA = '0;
			shadowD = '0;
			shadowRes = '0;
			shadowCmd = '0;
			shadowCcr = '0;
			ackExpected = 1'b0;
			checkCount = 0;
			errorCount = 0;
			testChecks = 0;
			testErrors = 0;
		end else begin
			// Ack exactly one cycle after a fresh request
			if (ackExpected) begin
				checkCount++;
				testChecks++;
			end
			if (busRsp.ack !== ackExpected) begin
				$display("error at %0t ns: busRsp.ack expected %0b, got %0b",
					$time, ackExpected, busRsp.ack);
				errorCount++;
				testErrors++;
			end
			ackExpected = bus.cyc & bus.stb & ~ackExpected;

			if (busRsp.ack && bus.cyc && bus.stb) begin
				if (!bus.we)
					compareRead(bus.adr, busRsp.dat);
				else if (bus.adr == addrOperandA)
					shadowA = bus.dat;
				else if (bus.adr == addrOperandD)
					shadowD = bus.dat;
				else if (bus.adr == addrCcr)
					shadowCcr = bus.dat[4:0];
				else if (bus.adr == addrCommand) begin
					shadowCmd = bus.dat[5:0];
					execute(shadowCmd);
				end
			end
			if (testEnd) begin
				$display("test %0d (%s) done: %0d checks, %0d errors",
					testNum, testName(testNum), testChecks, testErrors);
				testChecks = 0;
				testErrors = 0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/aluTb.sv ====
/*
 * Testbench for the ALU peripheral
 * Random Wishbone traffic in six tests, results judged by aluChecker
 */
`timescale 1ns/1ps
`default_nettype none

module aluTb import aluPkg::*, busPkg::*; ();

	localparam int clkPeriod = 4;
	localparam int numTests = 6;
	localparam int loops = 30;	// Iterations per test
	localparam int ackLimit = 16;	// Cycles before a transfer counts as lost
	localparam int watchdogNs = numTests * 200 * 10 * clkPeriod;

	logic clk = 1'b0;
	logic reset;
	wbRequest bus;
	wbResponse busRsp;
	logic [7:0] testNum;
	logic testEnd;
	int checkCount, errorCount;
	int ackFailures;

	aluTop i_dut (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.busRsp(busRsp)
	);

	aluChecker scoreboard (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.busRsp(busRsp),
		.testNum(testNum),
		.testEnd(testEnd),
		.checkCount(checkCount),
		.errorCount(errorCount)
	);

	always #(clkPeriod / 2) clk = ~clk;

	initial begin
		#(watchdogNs * 1ns);
		$display("watchdog expired after %0d ns, the tests did not finish", watchdogNs);
		$display("=== FAIL ===");
		$finish;
	end

	function automatic dataWord randWord();
		return dataWord'($urandom);
	endfunction

	// One classic cycle; stb held through the ack cycle, dropped after
	task automatic transfer(input logic write, input regAddr addr, input busWord data);
		int waited;
		@(negedge clk);
		bus.cyc = 1'b1;
		bus.stb = 1'b1;
		bus.we = write;
		bus.adr = addr;
		bus.dat = data;
		waited = 0;
		@(negedge clk);
		while (!busRsp.ack && waited < ackLimit) begin
			waited++;
			@(negedge clk);
		end
		if (!busRsp.ack) begin
			$display("no acknowledge from the DUT for register %0d at %0t ns", addr, $time);
			ackFailures++;
		end
		@(negedge clk);
		bus = '0;
	endtask

	// Preset operands and CCR, execute, read both outputs back
	task automatic runCommand(input logic [4:0] op, input logic isByte,
			input dataWord a, input dataWord d, input logic [4:0] ccrPreset);
		transfer(1'b1, addrOperandA, a);
		transfer(1'b1, addrOperandD, d);
		transfer(1'b1, addrCcr, busWord'(ccrPreset));
		transfer(1'b1, addrCommand, {10'd0, op, isByte});
		transfer(1'b0, addrResult, '0);
		transfer(1'b0, addrCcr, '0);
	endtask

	task automatic endTest();
		@(negedge clk);
		testEnd = 1'b1;
		@(negedge clk);
		testEnd = 1'b0;
	endtask

	initial begin
		logic [4:0] badOp;
		void'($urandom(46));
		bus = '0;
		reset = 1'b1;
		testNum = 8'd0;
		testEnd = 1'b0;
		ackFailures = 0;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		testNum = 8'd1;	// Reset values, then write and read back
		for (int i = 0; i < 5; i++)
			transfer(1'b0, regAddr'(i), '0);
		repeat (loops) begin
			transfer(1'b1, addrOperandA, randWord());
			transfer(1'b1, addrOperandD, randWord());
			transfer(1'b1, addrCcr, randWord());	// Upper bits must vanish
			transfer(1'b0, addrOperandA, '0);
			transfer(1'b0, addrOperandD, '0);
			transfer(1'b0, addrCcr, '0);
		end
		endTest();

		testNum = 8'd2;
		repeat (loops)
			runCommand(5'(opAnd) + 5'($urandom % 4), 1'($urandom), randWord(), randWord(),
				5'($urandom));
		endTest();

		testNum = 8'd3;
		repeat (loops)
			runCommand(5'(opAdd) + 5'($urandom % 4), 1'($urandom), randWord(), randWord(),
				5'($urandom));
		endTest();

		testNum = 8'd4;	// X comes in through the CCR preset
		repeat (loops)
			runCommand(5'(opAsl) + 5'($urandom % 8), 1'($urandom), randWord(), randWord(),
				5'($urandom));
		endTest();

		testNum = 8'd5;	// Valid digits in the low byte, junk above
		repeat (loops)
			runCommand(5'(opAbcd) + 5'($urandom % 2), 1'($urandom),
				{8'($urandom), 4'($urandom % 10), 4'($urandom % 10)},
				{8'($urandom), 4'($urandom % 10), 4'($urandom % 10)}, 5'($urandom));
		endTest();

		testNum = 8'd6;
		runCommand(5'(opAdd), 1'b0, randWord(), randWord(), 5'($urandom));
		repeat (loops) begin
			badOp = ($urandom % 2) ? 5'd0 : 5'(19 + $urandom % 13);	// 0 or 19..31
			transfer(1'b1, addrOperandA, randWord());
			transfer(1'b1, addrCommand, {10'd0, badOp, 1'($urandom)});
			transfer(1'b0, addrResult, '0);
			transfer(1'b0, addrCcr, '0);
			transfer(1'b0, addrCommand, '0);
		end
		endTest();

		@(negedge clk);
		$display("%0d tests, %0d checks, %0d errors, %0d missing acknowledges",
			numTests, checkCount, errorCount, ackFailures);
		if (errorCount == 0 && ackFailures == 0 && checkCount > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== aluTop.f ====
source/aluPkg.sv
source/busPkg.sv
source/aluShifter.sv
source/bcdCorrect.sv
source/aluCore.sv
source/aluRegs.sv
source/aluTop.sv
testbench/aluChecker.sv
testbench/aluTb.sv
